/* bench/spi_link_tb.sv */
// Directed testbench for spi_link_top with a loopback from the m pins to the s pins
// Inputs change 1 time unit after the rising clk edge and outputs are sampled there too
// The loopback copies pins at that same point, so it adds no clk cycle of delay
module spi_link_tb;

  localparam int WAIT_LIMIT = 1000;

  logic               clk;
  logic               arst_n;
  logic               monitor_en;
  spi_pkg::spi_word_t mtx_data;
  logic               mtx_valid;
  logic               mtx_ready;
  spi_pkg::spi_word_t mrx_data;
  logic               mrx_valid;
  logic               mrx_ready;
  spi_pkg::spi_word_t stx_data;
  logic               stx_valid;
  logic               stx_ready;
  spi_pkg::spi_pair_t srx_data;
  logic               srx_valid;
  logic               srx_ready;
  logic               s_spi_sclk;
  logic               s_spi_mosi;
  logic               s_spi_miso;
  logic               s_spi_cs;
  logic               m_spi_sclk;
  logic               m_spi_mosi;
  logic               m_spi_miso;
  logic               m_spi_cs;
  // Loopback copies of the pins and the bit-banged pin levels
  logic               loop_en;
  logic               lb_sclk = spi_pkg::SPI_CPOL;
  logic               lb_mosi = 1'b0;
  logic               lb_cs   = spi_pkg::CS_ACTIVE_LOW;
  logic               lb_miso = 1'b0;
  logic               bb_sclk;
  logic               bb_mosi;
  logic               bb_cs;
  logic               bb_miso;

  spi_link_top u_spi_link_top (.*);

  always #2 clk = ~clk;

  // Pin copies are taken where the DUT flops have settled
  always @(posedge clk) begin
    #1;
    lb_sclk = m_spi_sclk;
    lb_mosi = m_spi_mosi;
    lb_cs   = m_spi_cs;
    lb_miso = s_spi_miso;
  end

  assign s_spi_sclk = loop_en ? lb_sclk : bb_sclk;
  assign s_spi_mosi = loop_en ? lb_mosi : bb_mosi;
  assign s_spi_cs   = loop_en ? lb_cs : bb_cs;
  assign m_spi_miso = loop_en ? lb_miso : bb_miso;

  // *************************************************************************
  // Compare tasks and small helpers
  // *************************************************************************

  task automatic check_word(input string name, input spi_pkg::spi_word_t got,
                            input spi_pkg::spi_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_pair(input string name, input spi_pkg::spi_pair_t got,
                            input spi_pkg::spi_pair_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Gave up after %0d cycles waiting for %s", WAIT_LIMIT, what);
    $display("Errors found");
    $fatal(1, "wait timed out");
  endtask

  function automatic spi_pkg::spi_word_t rand_word();
    return spi_pkg::spi_word_t'($urandom());
  endfunction

  // MOSI lands in the upper half of the pair
  function automatic spi_pkg::spi_pair_t make_pair(input spi_pkg::spi_word_t mosi,
                                                   input spi_pkg::spi_word_t miso);
    spi_pkg::spi_pair_t pair;
    pair.mosi = mosi;
    pair.miso = miso;
    return pair;
  endfunction

  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(posedge clk);
      #1;
    end
  endtask

  // *************************************************************************
  // Stream drivers
  // *************************************************************************

  // Ready never depends on valid here, so it can be read right after driving
  task automatic send_word(input spi_pkg::spi_word_t word);
    int waited;
    waited    = 0;
    mtx_data  = word;
    mtx_valid = 1'b1;
    while (mtx_ready !== 1'b1) begin
      if (waited == WAIT_LIMIT) report_timeout("mtx_ready");
      @(posedge clk);
      #1;
      waited++;
    end
    @(posedge clk);
    #1;
    mtx_valid = 1'b0;
  endtask

  task automatic push_reply(input spi_pkg::spi_word_t word);
    int waited;
    waited    = 0;
    stx_data  = word;
    stx_valid = 1'b1;
    while (stx_ready !== 1'b1) begin
      if (waited == WAIT_LIMIT) report_timeout("stx_ready");
      @(posedge clk);
      #1;
      waited++;
    end
    @(posedge clk);
    #1;
    stx_valid = 1'b0;
  endtask

  task automatic wait_mrx_valid();
    int waited;
    waited = 0;
    while (mrx_valid !== 1'b1) begin
      if (waited == WAIT_LIMIT) report_timeout("mrx_valid");
      @(posedge clk);
      #1;
      waited++;
    end
  endtask

  // Ready is raised only once the word is visible, for a single cycle
  task automatic expect_mrx(input spi_pkg::spi_word_t exp);
    wait_mrx_valid();
    check_word("mrx_data", mrx_data, exp);
    mrx_ready = 1'b1;
    @(posedge clk);
    #1;
    mrx_ready = 1'b0;
  endtask

  task automatic expect_srx(input spi_pkg::spi_pair_t exp);
    int waited;
    waited = 0;
    while (srx_valid !== 1'b1) begin
      if (waited == WAIT_LIMIT) report_timeout("srx_valid");
      @(posedge clk);
      #1;
      waited++;
    end
    check_pair("srx_data", srx_data, exp);
    srx_ready = 1'b1;
    @(posedge clk);
    #1;
    srx_ready = 1'b0;
  endtask

  // *************************************************************************
  // Bit-banged transfer for monitor mode
  // *************************************************************************

  // Every cycle the bridge must mirror the s pins and keep the master closed
  task automatic watch_bridge(input int count);
    repeat (count) begin
      @(posedge clk);
      #1;
      check_bit("m_spi_sclk", m_spi_sclk, s_spi_sclk);
      check_bit("m_spi_mosi", m_spi_mosi, s_spi_mosi);
      check_bit("m_spi_cs", m_spi_cs, s_spi_cs);
      check_bit("s_spi_miso", s_spi_miso, m_spi_miso);
      check_bit("mtx_ready", mtx_ready, 1'b0);
    end
  endtask

  task automatic present_bits(inout spi_pkg::spi_word_t mosi_sr,
                              inout spi_pkg::spi_word_t miso_sr);
    bb_mosi = mosi_sr[spi_pkg::WORD_BITS-1];
    bb_miso = miso_sr[spi_pkg::WORD_BITS-1];
    mosi_sr = mosi_sr << 1;
    miso_sr = miso_sr << 1;
  endtask

  // With CPHA clear data moves on trailing edges, otherwise on leading edges
  task automatic bang_transfer(input spi_pkg::spi_word_t mosi_word,
                               input spi_pkg::spi_word_t miso_word);
    spi_pkg::spi_word_t mosi_sr;
    spi_pkg::spi_word_t miso_sr;
    int                 edge_idx;
    mosi_sr = mosi_word;
    miso_sr = miso_word;
    bb_cs   = ~spi_pkg::CS_ACTIVE_LOW;
    if (!spi_pkg::SPI_CPHA) present_bits(mosi_sr, miso_sr);
    watch_bridge(spi_pkg::CLK_DIV);
    for (edge_idx = 0; edge_idx < 2 * spi_pkg::WORD_BITS; edge_idx++) begin
      bb_sclk = ~bb_sclk;
      if ((edge_idx % 2) != int'(spi_pkg::SPI_CPHA)) present_bits(mosi_sr, miso_sr);
      watch_bridge(spi_pkg::CLK_DIV);
    end
    bb_cs   = spi_pkg::CS_ACTIVE_LOW;
    bb_mosi = 1'b0;
    bb_miso = 1'b0;
    watch_bridge(spi_pkg::CLK_DIV);
  endtask

  // *************************************************************************
  // Directed tests
  // *************************************************************************

  task automatic reset_values();
    check_bit("m_spi_cs", m_spi_cs, spi_pkg::CS_ACTIVE_LOW);
    check_bit("m_spi_sclk", m_spi_sclk, spi_pkg::SPI_CPOL);
    check_bit("mrx_valid", mrx_valid, 1'b0);
    check_bit("srx_valid", srx_valid, 1'b0);
    check_bit("s_spi_miso", s_spi_miso, 1'b0);
    check_bit("mtx_ready", mtx_ready, 1'b1);
    check_bit("stx_ready", stx_ready, 1'b1);
  endtask

  task automatic default_reply();
    spi_pkg::spi_word_t word;
    word = rand_word();
    send_word(word);
    expect_mrx(spi_pkg::DEFAULT_MISO);
    expect_srx(make_pair(word, spi_pkg::DEFAULT_MISO));
  endtask

  task automatic queued_replies();
    spi_pkg::spi_word_t r1;
    spi_pkg::spi_word_t r2;
    spi_pkg::spi_word_t m1;
    spi_pkg::spi_word_t m2;
    r1 = rand_word();
    r2 = rand_word();
    m1 = rand_word();
    m2 = rand_word();
    push_reply(r1);
    push_reply(r2);
    send_word(m1);
    expect_mrx(r1);
    send_word(m2);
    expect_mrx(r2);
    expect_srx(make_pair(m1, r1));
    expect_srx(make_pair(m2, r2));
  endtask

  // An unread mrx word must keep the master off the bus entirely
  task automatic back_pressure();
    spi_pkg::spi_word_t q1;
    spi_pkg::spi_word_t q2;
    spi_pkg::spi_word_t w1;
    spi_pkg::spi_word_t w2;
    spi_pkg::spi_word_t w3;
    q1 = rand_word();
    q2 = rand_word();
    w1 = rand_word();
    w2 = rand_word();
    w3 = rand_word();
    push_reply(q1);
    push_reply(q2);
    send_word(w1);
    wait_mrx_valid();
    mtx_data  = w2;
    mtx_valid = 1'b1;
    repeat (300) begin
      @(posedge clk);
      #1;
      check_bit("mtx_ready", mtx_ready, 1'b0);
      check_bit("m_spi_cs", m_spi_cs, spi_pkg::CS_ACTIVE_LOW);
    end
    expect_mrx(q1);
    send_word(w2);
    expect_mrx(q2);
    send_word(w3);
    expect_mrx(spi_pkg::DEFAULT_MISO);
    expect_srx(make_pair(w1, q1));
    expect_srx(make_pair(w2, q2));
    expect_srx(make_pair(w3, spi_pkg::DEFAULT_MISO));
  endtask

  // The pending reply must survive a monitored transfer untouched
  task automatic monitor_pass_through();
    spi_pkg::spi_word_t reply;
    spi_pkg::spi_word_t mosi_word;
    spi_pkg::spi_word_t miso_word;
    spi_pkg::spi_word_t next_word;
    reply     = rand_word();
    mosi_word = rand_word();
    miso_word = rand_word();
    next_word = rand_word();
    push_reply(reply);
    bb_sclk = spi_pkg::SPI_CPOL;
    bb_cs   = spi_pkg::CS_ACTIVE_LOW;
    bb_mosi = 1'b0;
    bb_miso = 1'b0;
    loop_en = 1'b0;
    idle_cycles(2);
    monitor_en = 1'b1;
    watch_bridge(4);
    bang_transfer(mosi_word, miso_word);
    expect_srx(make_pair(mosi_word, miso_word));
    monitor_en = 1'b0;
    idle_cycles(2);
    loop_en = 1'b1;
    idle_cycles(2);
    send_word(next_word);
    expect_mrx(reply);
    expect_srx(make_pair(next_word, reply));
  endtask

  initial begin
    void'($urandom(32'h02463941));
    clk        = 1'b0;
    arst_n     = 1'b0;
    monitor_en = 1'b0;
    mtx_data   = '0;
    mtx_valid  = 1'b0;
    mrx_ready  = 1'b0;
    stx_data   = '0;
    stx_valid  = 1'b0;
    srx_ready  = 1'b0;
    loop_en    = 1'b1;
    bb_sclk    = spi_pkg::SPI_CPOL;
    bb_cs      = spi_pkg::CS_ACTIVE_LOW;
    bb_mosi    = 1'b0;
    bb_miso    = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    idle_cycles(2);
    reset_values();
    default_reply();
    queued_replies();
    back_pressure();
    monitor_pass_through();
    $display("No errors");
    $finish;
  end

endmodule

/* hdl/spi_link_top.sv */
// SPI link with one master engine, one slave engine and a pin router
// All streams are valid/ready, and monitor_en may only change while the bus is idle
module spi_link_top (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               monitor_en,
  // Words for the master to send
  input  spi_pkg::spi_word_t mtx_data,
  input  logic               mtx_valid,
  output logic               mtx_ready,
  // Words the master captured on MISO
  output spi_pkg::spi_word_t mrx_data,
  output logic               mrx_valid,
  input  logic               mrx_ready,
  // Slave reply queue
  input  spi_pkg::spi_word_t stx_data,
  input  logic               stx_valid,
  output logic               stx_ready,
  // Pairs seen by the slave
  output spi_pkg::spi_pair_t srx_data,
  output logic               srx_valid,
  input  logic               srx_ready,
  // Slave side pins
  input  logic               s_spi_sclk,
  input  logic               s_spi_mosi,
  output logic               s_spi_miso,
  input  logic               s_spi_cs,
  // Master side pins
  output logic               m_spi_sclk,
  output logic               m_spi_mosi,
  input  logic               m_spi_miso,
  output logic               m_spi_cs
);

  spi_pins_if mst_pins ();
  spi_pins_if slv_pins ();

  // The master stops taking words while the bridge owns its pins
  spi_master_engine u_master (
    .clk      (clk),
    .arst_n   (arst_n),
    .enable   (!monitor_en),
    .tx_data  (mtx_data),
    .tx_valid (mtx_valid),
    .tx_ready (mtx_ready),
    .rx_data  (mrx_data),
    .rx_valid (mrx_valid),
    .rx_ready (mrx_ready),
    .pins     (mst_pins.drv)
  );

  spi_slave_engine u_slave (
    .clk         (clk),
    .arst_n      (arst_n),
    .listen_only (monitor_en),
    .pins        (slv_pins.lsn),
    .tx_data     (stx_data),
    .tx_valid    (stx_valid),
    .tx_ready    (stx_ready),
    .rx_data     (srx_data),
    .rx_valid    (srx_valid),
    .rx_ready    (srx_ready)
  );

  spi_port_mux u_port_mux (
    .monitor_en (monitor_en),
    .mst        (mst_pins.rtr_m),
    .slv        (slv_pins.rtr_s),
    .s_spi_sclk (s_spi_sclk),
    .s_spi_mosi (s_spi_mosi),
    .s_spi_cs   (s_spi_cs),
    .m_spi_miso (m_spi_miso),
    .s_spi_miso (s_spi_miso),
    .m_spi_sclk (m_spi_sclk),
    .m_spi_mosi (m_spi_mosi),
    .m_spi_cs   (m_spi_cs)
  );

endmodule

/* hdl/spi_master_engine.sv */
// SPI master for single 16 bit words with a fixed mode taken from spi_pkg
// MISO is sampled one clk after the sample edge to cover the slave sync delay
// A captured word blocks the next transfer until it has been read
module spi_master_engine (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               enable,
  input  spi_pkg::spi_word_t tx_data,
  input  logic               tx_valid,
  output logic               tx_ready,
  output spi_pkg::spi_word_t rx_data,
  output logic               rx_valid,
  input  logic               rx_ready,
  spi_pins_if.drv            pins
);

  localparam int MSB    = spi_pkg::WORD_BITS - 1;
  localparam int DIV_W  = (spi_pkg::CLK_DIV > 1) ? $clog2(spi_pkg::CLK_DIV) : 1;
  localparam int EDGE_W = $clog2(2 * spi_pkg::WORD_BITS);

  typedef enum logic [1:0] {ST_IDLE, ST_LEAD, ST_SHIFT, ST_TRAIL} state_t;

  state_t              state;
  logic [DIV_W-1:0]    div_cnt;
  logic [EDGE_W-1:0]   edge_cnt;
  logic                sclk_q;
  logic                cs_act_q;
  logic                mosi_q;
  logic                sample_pend;
  logic                half_done;
  logic                sample_now;
  logic                last_edge;
  logic                start;
  spi_pkg::spi_word_t  tx_sr;
  spi_pkg::spi_word_t  rx_sr;

  // New words are taken only while idle, enabled and with the last result read
  assign tx_ready   = enable && (state == ST_IDLE) && !rx_valid;
  assign start      = tx_valid && tx_ready;
  assign half_done  = (div_cnt == DIV_W'(spi_pkg::CLK_DIV - 1));
  // Even edge numbers are leading edges, so CPHA picks the sampling parity
  assign sample_now = (edge_cnt[0] == spi_pkg::SPI_CPHA);
  assign last_edge  = (edge_cnt == EDGE_W'(2 * spi_pkg::WORD_BITS - 1));

  assign pins.sclk = sclk_q;
  assign pins.cs   = cs_act_q ^ spi_pkg::CS_ACTIVE_LOW;
  assign pins.mosi = mosi_q;

  // *************************************************************************
  // Transfer sequencing
  // *************************************************************************

  // Lead and trail each last one half period and the shift phase has one
  // sclk edge at the end of every half period
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= ST_IDLE;
      div_cnt     <= '0;
      edge_cnt    <= '0;
      sclk_q      <= spi_pkg::SPI_CPOL;
      cs_act_q    <= 1'b0;
      mosi_q      <= 1'b0;
      sample_pend <= 1'b0;
      rx_valid    <= 1'b0;
    end else begin
      sample_pend <= 1'b0;
      if (rx_valid && rx_ready) begin
        rx_valid <= 1'b0;
      end
      case (state)
        ST_IDLE: begin
          if (start) begin
            state    <= ST_LEAD;
            cs_act_q <= 1'b1;
            mosi_q   <= tx_data[MSB];
            div_cnt  <= '0;
            edge_cnt <= '0;
          end
        end
        ST_LEAD: begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done) begin
            state <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done) begin
            sclk_q   <= ~sclk_q;
            edge_cnt <= edge_cnt + 1'b1;
            if (sample_now) begin
              sample_pend <= 1'b1;
            end else begin
              mosi_q <= tx_sr[MSB];
            end
            if (last_edge) begin
              state <= ST_TRAIL;
            end
          end
        end
        default: begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done) begin
            state    <= ST_IDLE;
            cs_act_q <= 1'b0;
            rx_valid <= 1'b1;
          end
        end
      endcase
    end
  end

  // With CPHA set the first shift edge presents the MSB again
  always_ff @(posedge clk) begin
    if (start) begin
      tx_sr <= spi_pkg::SPI_CPHA ? tx_data : {tx_data[MSB-1:0], 1'b0};
    end else if ((state == ST_SHIFT) && half_done && !sample_now) begin
      tx_sr <= {tx_sr[MSB-1:0], 1'b0};
    end
    if (sample_pend) begin
      rx_sr <= {rx_sr[MSB-1:0], pins.miso};
    end
    if ((state == ST_TRAIL) && half_done) begin
      rx_data <= rx_sr;
    end
  end

  a_sclk_in_cs: assert property (@(posedge clk) disable iff (!arst_n)
    (pins.sclk != $past(pins.sclk)) |-> cs_act_q);

  a_rx_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_data)));

endmodule

/* hdl/spi_pins_if.sv */
// Four wire SPI bundle between an engine and the pin router
// miso_pin is the level on the external MISO pin and only matters on the slave side
interface spi_pins_if;

  logic sclk;
  logic cs;
  logic mosi;
  // Value the engine itself puts on MISO
  logic miso;
  // Level actually present on the MISO pin after routing
  logic miso_pin;

  // Master engine side
  modport drv (output sclk, cs, mosi, input miso);

  // Slave engine side, which may also observe the real MISO line
  modport lsn (input sclk, cs, mosi, miso_pin, output miso);

  // Router side of the master instance
  modport rtr_m (input sclk, cs, mosi, output miso);

  // Router side of the slave instance
  modport rtr_s (output sclk, cs, mosi, miso_pin, input miso);

endinterface

/* hdl/spi_pkg.sv */
// Shared SPI word types and link configuration for every block of the design
// All values are elaboration constants, and run time changes are not supported
// CLK_DIV below 3 breaks the slave synchronizer margin
package spi_pkg;

  // *************************************************************************
  // Word format
  // *************************************************************************

  // Bits per transfer, shifted MSB first
  localparam int WORD_BITS = 16;

  // One SPI word as seen on either data line
  typedef logic [WORD_BITS-1:0] spi_word_t;

  // Both data lines of one transfer, MOSI in the upper half
  typedef struct packed {
    spi_word_t mosi;
    spi_word_t miso;
  } spi_pair_t;

  // *************************************************************************
  // Bus mode
  // *************************************************************************

  // Idle level of sclk
  localparam bit SPI_CPOL = 1'b0;

  // Zero samples on the first edge of each bit and one samples on the second
  localparam bit SPI_CPHA = 1'b0;

  // Chip select is driven low while a transfer is running
  localparam bit CS_ACTIVE_LOW = 1'b1;

  // System clock cycles per sclk half period
  localparam int CLK_DIV = 4;

  // *************************************************************************
  // Slave behaviour
  // *************************************************************************

  // Word shifted out on MISO when no reply is queued
  localparam spi_word_t DEFAULT_MISO = 16'hCAFE;

  // Entries in each slave side queue
  localparam int FIFO_DEPTH = 4;

endpackage

/* hdl/spi_port_mux.sv */
// Combinational pin router between the two engines and the external SPI pins
// monitor_en must only change while both sides are idle
module spi_port_mux (
  input  logic      monitor_en,
  spi_pins_if.rtr_m mst,
  spi_pins_if.rtr_s slv,
  input  logic      s_spi_sclk,
  input  logic      s_spi_mosi,
  input  logic      s_spi_cs,
  input  logic      m_spi_miso,
  output logic      s_spi_miso,
  output logic      m_spi_sclk,
  output logic      m_spi_mosi,
  output logic      m_spi_cs
);

  // *************************************************************************
  // External pins
  // *************************************************************************

  // Monitor mode bridges the slave pins onto the master pins unchanged
  always_comb begin
    if (monitor_en) begin
      m_spi_sclk = s_spi_sclk;
      m_spi_mosi = s_spi_mosi;
      m_spi_cs   = s_spi_cs;
      s_spi_miso = m_spi_miso;
    end else begin
      m_spi_sclk = mst.sclk;
      m_spi_mosi = mst.mosi;
      m_spi_cs   = mst.cs;
      s_spi_miso = slv.miso;
    end
  end

  // *************************************************************************
  // Engine side
  // *************************************************************************

  // The slave always watches the s pins, in either mode
  assign slv.sclk = s_spi_sclk;
  assign slv.mosi = s_spi_mosi;
  assign slv.cs   = s_spi_cs;

  // The real MISO pin level, which is the far end's reply in monitor mode
  assign slv.miso_pin = s_spi_miso;

  // The master hears nothing while its pins are handed to the bridge
  assign mst.miso = monitor_en ? 1'b0 : m_spi_miso;

endmodule

/* hdl/spi_slave_engine.sv */
// SPI slave that oversamples its pins with clk through two sync flops
// The sclk half period must span at least 3 clk cycles for edges to resolve
// A received pair is lost when the rx queue is full at the end of a word
module spi_slave_engine (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               listen_only,
  spi_pins_if.lsn            pins,
  input  spi_pkg::spi_word_t tx_data,
  input  logic               tx_valid,
  output logic               tx_ready,
  output spi_pkg::spi_pair_t rx_data,
  output logic               rx_valid,
  input  logic               rx_ready
);

  localparam int MSB   = spi_pkg::WORD_BITS - 1;
  localparam int CNT_W = $clog2(spi_pkg::WORD_BITS);

  logic [2:0]         sclk_s;
  logic [2:0]         cs_s;
  logic [1:0]         mosi_s;
  logic [1:0]         miso_s;
  logic               cs_act;
  logic               cs_start;
  logic               cs_end;
  logic               sclk_edge;
  logic               sample_edge;
  logic               shift_edge;
  logic               miso_bit;
  logic [CNT_W-1:0]   bit_cnt;
  logic               miso_q;
  logic               pair_vld;
  logic               overflow;
  logic               txq_valid;
  logic               rxq_ready;
  spi_pkg::spi_word_t txq_data;
  spi_pkg::spi_word_t reply_word;
  spi_pkg::spi_word_t tx_sr;
  spi_pkg::spi_pair_t rx_pair;

  // *************************************************************************
  // Pin synchronizers and edge decode
  // *************************************************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sclk_s <= {3{spi_pkg::SPI_CPOL}};
      cs_s   <= {3{spi_pkg::CS_ACTIVE_LOW}};
      mosi_s <= '0;
      miso_s <= '0;
    end else begin
      sclk_s <= {sclk_s[1:0], pins.sclk};
      cs_s   <= {cs_s[1:0], pins.cs};
      mosi_s <= {mosi_s[0], pins.mosi};
      miso_s <= {miso_s[0], pins.miso_pin};
    end
  end

  assign cs_act    = cs_s[1] ^ spi_pkg::CS_ACTIVE_LOW;
  assign cs_start  = cs_act & ~(cs_s[2] ^ spi_pkg::CS_ACTIVE_LOW);
  assign cs_end    = ~cs_act & (cs_s[2] ^ spi_pkg::CS_ACTIVE_LOW);
  assign sclk_edge = sclk_s[1] ^ sclk_s[2];
  // A leading edge leaves the idle level, and CPHA swaps the two edge roles
  assign sample_edge = sclk_edge & ((sclk_s[2] == spi_pkg::SPI_CPOL) ^ spi_pkg::SPI_CPHA);
  assign shift_edge  = sclk_edge & cs_act & ~sample_edge;

  // In monitor use the far end's MISO is recorded instead of our own bit
  assign miso_bit  = listen_only ? miso_s[1] : miso_q;
  assign pins.miso = miso_q;

  // Only a listening slave leaves the reply queue alone
  assign reply_word = txq_valid ? txq_data : spi_pkg::DEFAULT_MISO;

  word_fifo #(.payload_t(spi_pkg::spi_word_t)) u_tx_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (tx_data),
    .in_valid  (tx_valid),
    .in_ready  (tx_ready),
    .out_data  (txq_data),
    .out_valid (txq_valid),
    .out_ready (cs_start & ~listen_only)
  );

  // *************************************************************************
  // Bit control
  // *************************************************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt  <= '0;
      miso_q   <= 1'b0;
      pair_vld <= 1'b0;
      overflow <= 1'b0;
    end else begin
      pair_vld <= 1'b0;
      if (pair_vld && !rxq_ready) begin
        overflow <= 1'b1;
      end
      if (cs_start) begin
        bit_cnt <= '0;
        miso_q  <= listen_only ? 1'b0 : reply_word[MSB];
      end else if (cs_end) begin
        bit_cnt <= '0;
        miso_q  <= 1'b0;
      end else if (cs_act) begin
        if (shift_edge && !listen_only) begin
          miso_q <= tx_sr[MSB];
        end
        if (sample_edge) begin
          bit_cnt  <= (bit_cnt == CNT_W'(MSB)) ? '0 : bit_cnt + 1'b1;
          pair_vld <= (bit_cnt == CNT_W'(MSB));
        end
      end
    end
  end

  // The finished pair sits in rx_pair for the cycle in which pair_vld is high
  always_ff @(posedge clk) begin
    if (cs_start) begin
      tx_sr <= spi_pkg::SPI_CPHA ? reply_word : {reply_word[MSB-1:0], 1'b0};
    end else if (shift_edge) begin
      tx_sr <= {tx_sr[MSB-1:0], 1'b0};
    end
    if (sample_edge && cs_act) begin
      rx_pair.mosi <= {rx_pair.mosi[MSB-1:0], mosi_s[1]};
      rx_pair.miso <= {rx_pair.miso[MSB-1:0], miso_bit};
    end
  end

  word_fifo #(.payload_t(spi_pkg::spi_pair_t)) u_rx_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (rx_pair),
    .in_valid  (pair_vld),
    .in_ready  (rxq_ready),
    .out_data  (rx_data),
    .out_valid (rx_valid),
    .out_ready (rx_ready)
  );

  // The far end must keep sclk quiet outside chip select
  a_sample_in_cs: assert property (@(posedge clk) disable iff (!arst_n)
    sample_edge |-> cs_act);

  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) !overflow)
    else $error("slave rx queue overflow, a received pair was lost");

endmodule

/* hdl/word_fifo.sv */
// Circular valid/ready queue of spi_pkg::FIFO_DEPTH entries for any payload type
// Output data comes straight from the storage array without a register stage
module word_fifo #(
  parameter type payload_t = spi_pkg::spi_word_t
) (
  input  logic     clk,
  input  logic     arst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int PTR_W = (spi_pkg::FIFO_DEPTH > 1) ? $clog2(spi_pkg::FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(spi_pkg::FIFO_DEPTH + 1);

  payload_t         mem [spi_pkg::FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Pointers wrap explicitly so that depths other than powers of two work
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(spi_pkg::FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_ready  = (count != CNT_W'(spi_pkg::FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // A simultaneous push and pop leaves the fill level unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // The fill level must stay within the storage over any push and pop sequence
  a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
    count <= CNT_W'(spi_pkg::FIFO_DEPTH));

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the SPI link testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module spi_link_tb \
    -f sources.f -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vspi_link_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "No errors"; then
  exit 0
else
  echo "Pass line not found in simulation output"
  exit 1
fi

/* sources.f */
hdl/spi_pkg.sv
hdl/spi_pins_if.sv
hdl/word_fifo.sv
hdl/spi_master_engine.sv
hdl/spi_slave_engine.sv
hdl/spi_port_mux.sv
hdl/spi_link_top.sv
bench/spi_link_tb.sv
